//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wall
TOP       = tb_ps2
FLIST     = tb.f
OBJDIR    = obj_dir

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q -F '** PASS **'

clean:
	rm -rf $(OBJDIR)

.PHONY: sim clean

//--- source/ps2_buf_arbiter.sv
// ----------------------------------------
// Output buffer arbiter
// Mouse first, then keyboard, one byte held
// ----------------------------------------
`timescale 1ns/10ps

module ps2_buf_arbiter import ps2_pkg::*; (
	input  logic      wb_clk_i,
	input  logic      wb_rst_i,
	ps2_rx_if.sink    kbd,
	ps2_rx_if.sink    mse,
	input  logic      kbd_dis_i,    // Control byte disables
	input  logic      mse_dis_i,
	input  logic      buf_read_i,   // Host consumed the byte
	output logic      obf_o,        // Buffer full
	output logic      aux_o,        // Held byte is from the mouse
	output logic      perr_o,
	output ps2_byte_t buf_byte_o
);

	logic grant_mse;
	logic grant_kbd;

	// Only an empty buffer is handed out
	assign grant_mse = ~obf_o & mse.valid & ~mse_dis_i;
	assign grant_kbd = ~obf_o & kbd.valid & ~kbd_dis_i & ~grant_mse;

	assign mse.ack = grant_mse;     // Single cycle, obf blocks the next
	assign kbd.ack = grant_kbd;

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			obf_o  <= 1'b0;
			aux_o  <= 1'b0;
			perr_o <= 1'b0;
		end else if (grant_mse || grant_kbd) begin
			obf_o  <= 1'b1;
			aux_o  <= grant_mse;
			perr_o <= grant_mse ? mse.perr : kbd.perr;
		end else if (buf_read_i)
			obf_o <= 1'b0;              // Source and parity stay for status
	end

	always_ff @(posedge wb_clk_i) begin
		if (grant_mse)
			buf_byte_o <= mse.data;
		else if (grant_kbd)
			buf_byte_o <= kbd.data;
	end

endmodule

//--- source/ps2_host_regs.sv
// ----------------------------------------
// 8042 style host registers
// Wishbone decode, command flags, control byte,
// status, read mux and level interrupts
// ----------------------------------------
`timescale 1ns/10ps

module ps2_host_regs import ps2_pkg::*; (
	input  logic        wb_clk_i,
	input  logic        wb_rst_i,
	input  logic [15:0] wb_dat_i,
	output logic [15:0] wb_dat_o,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic [2:1]  wb_adr_i,
	input  logic [1:0]  wb_sel_i,
	input  logic        wb_we_i,
	output logic        wb_ack_o,
	output logic        wb_tgk_o,     // Keyboard IRQ, level
	output logic        wb_tgm_o,     // Mouse IRQ, level
	input  logic        obf_i,
	input  logic        aux_i,
	input  logic        perr_i,
	input  ps2_byte_t   buf_byte_i,
	output logic        buf_read_o,
	output logic        kbd_dis_o,
	output logic        mse_dis_o,
	output logic        tx_start_o,
	output ps2_byte_t   tx_byte_o,
	input  logic        tx_busy_i,
	input  logic        tx_timeout_i
);

	ps2_byte_t  dat_in, dat_out, status;
	ps2_byte_t  ctrl_q;             // Control byte
	ps2_byte_t  reply_q;            // Command reply for the next data read
	logic [2:0] reg_addr;
	logic       ack, wr, rd;
	logic       dat_wr, dat_rd, cmd_wr;
	logic       reply_cmd;
	logic       reply_vld_q, ctrl_wr_q, mse_wr_q, a2_q, to_q;

	// ----------------------------------------
	// Bus decode, byte lane by wb_sel_i[0]
	assign dat_in   = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];
	assign wb_dat_o = wb_sel_i[0] ? {8'h00, dat_out} : {dat_out, 8'h00};
	assign reg_addr = {wb_adr_i, wb_sel_i[1]};
	assign ack      = wb_stb_i & wb_cyc_i;   // Zero wait state
	assign wb_ack_o = ack;
	assign wr       = ack & wb_we_i;
	assign rd       = ack & ~wb_we_i;
	assign dat_wr   = wr & (reg_addr == DATA_ADDR);
	assign dat_rd   = rd & (reg_addr == DATA_ADDR);
	assign cmd_wr   = wr & (reg_addr == CMD_ADDR);

	assign reply_cmd = (dat_in == CMD_RD_CTRL) || (dat_in == CMD_SELF_TEST) ||
	                   (dat_in == CMD_MSE_TEST);

	assign buf_read_o = dat_rd & ~reply_vld_q;   // Reply is read first
	assign tx_start_o = dat_wr & mse_wr_q;
	assign tx_byte_o  = dat_in;
	assign kbd_dis_o  = ctrl_q[CT_KDIS];
	assign mse_dis_o  = ctrl_q[CT_MDIS];

	// Command flags
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			ctrl_q      <= CTRL_DEFAULT;
			reply_vld_q <= 1'b0;
			ctrl_wr_q   <= 1'b0;
			mse_wr_q    <= 1'b0;
			a2_q        <= 1'b0;
			to_q        <= 1'b0;
		end else begin
			if (cmd_wr) begin
				a2_q      <= 1'b1;
				ctrl_wr_q <= (dat_in == CMD_WR_CTRL);  // A new command drops a pending one
				mse_wr_q  <= (dat_in == CMD_MSE_WRITE);
				if (reply_cmd)
					reply_vld_q <= 1'b1;
				if (dat_in == CMD_MSE_WRITE)
					to_q <= 1'b0;
			end else if (dat_wr) begin
				a2_q      <= 1'b0;
				ctrl_wr_q <= 1'b0;
				mse_wr_q  <= 1'b0;               // Byte went to the transmitter
				if (ctrl_wr_q)
					ctrl_q <= dat_in;
			end else if (dat_rd)
				reply_vld_q <= 1'b0;
			if (tx_timeout_i)
				to_q <= 1'b1;                    // Sticky
		end
	end

	// Reply byte, taken when the command is written
	always_ff @(posedge wb_clk_i) begin
		if (cmd_wr && reply_cmd) begin
			case (dat_in)
				CMD_RD_CTRL:   reply_q <= ctrl_q;
				CMD_SELF_TEST: reply_q <= SELF_TEST_OK;
				default:       reply_q <= MSE_TEST_OK;
			endcase
		end
	end

	// ----------------------------------------
	// Status and read mux
	always_comb begin
		status          = 8'h00;
		status[ST_OBF]  = reply_vld_q | obf_i;
		status[ST_BUSY] = tx_busy_i;
		status[ST_SYS]  = 1'b1;                 // Always past power-on
		status[ST_A2]   = a2_q;
		status[ST_INH]  = 1'b1;                 // Keyboard never locked
		status[ST_AUX]  = aux_i;
		status[ST_TO]   = to_q;
		status[ST_PERR] = perr_i;
	end

	assign dat_out = (reg_addr == DATA_ADDR) ? (reply_vld_q ? reply_q : buf_byte_i) : status;

	// Level interrupts follow the buffer
	assign wb_tgk_o = obf_i & ~aux_i & ctrl_q[CT_KINT];
	assign wb_tgm_o = obf_i & aux_i & ctrl_q[CT_MINT];

endmodule

//--- source/ps2_pkg.sv
// ----------------------------------------
// PS/2 controller shared definitions
// Register addresses, 8042 commands, reply bytes
// and status/control bit positions
// ----------------------------------------
package ps2_pkg;

	typedef logic [7:0] ps2_byte_t;           // One byte, PS/2 side or bus side

	// Decoded {wb_adr_i[2:1], wb_sel_i[1]}
	localparam logic [2:0] DATA_ADDR = 3'b000; // Port 0x60
	localparam logic [2:0] CMD_ADDR  = 3'b100; // Port 0x64

	// ----------------------------------------
	// Controller commands written to 0x64
	localparam ps2_byte_t CMD_RD_CTRL   = 8'h20; // Next data read returns control byte
	localparam ps2_byte_t CMD_WR_CTRL   = 8'h60; // Next data write loads control byte
	localparam ps2_byte_t CMD_MSE_TEST  = 8'hA9; // Mouse interface test
	localparam ps2_byte_t CMD_SELF_TEST = 8'hAA; // Controller self test
	localparam ps2_byte_t CMD_MSE_WRITE = 8'hD4; // Next data write goes to the mouse

	localparam ps2_byte_t SELF_TEST_OK = 8'h55;
	localparam ps2_byte_t MSE_TEST_OK  = 8'h00; // Lines not stuck
	localparam ps2_byte_t CTRL_DEFAULT = 8'h47; // XLAT, SYSF, both interrupts on

	// Status register bits
	localparam int ST_OBF  = 0;
	localparam int ST_BUSY = 1;               // Mouse transmit in progress
	localparam int ST_SYS  = 2;
	localparam int ST_A2   = 3;               // Last write went to 0x64
	localparam int ST_INH  = 4;
	localparam int ST_AUX  = 5;               // Buffered byte came from the mouse
	localparam int ST_TO   = 6;
	localparam int ST_PERR = 7;

	// Control byte bits
	localparam int CT_KINT = 0;
	localparam int CT_MINT = 1;
	localparam int CT_KDIS = 4;
	localparam int CT_MDIS = 5;

endpackage

//--- source/ps2_rx.sv
// ----------------------------------------
// PS/2 device-to-host frame receiver
// Start, 8 data LSB first, odd parity, stop
// Holds the clock low while a byte waits
// ----------------------------------------
`timescale 1ns/10ps

module ps2_rx import ps2_pkg::*; (
	input  logic     wb_clk_i,
	input  logic     wb_rst_i,
	input  logic     ps2_clk_i,     // Clock pad, after wired AND
	input  logic     ps2_dat_i,     // Data pad
	output logic     ps2_clk_oe_o,  // Pull clock low
	ps2_rx_if.source rx
);

	logic [1:0]  clk_sync;
	logic [1:0]  dat_sync;
	logic        clk_prev;          // Last synchronized clock level
	logic [2:0]  hold_q;            // Masks our own inhibit edge
	logic [3:0]  bit_cnt_q;         // Bits taken of the current frame
	logic [8:0]  frame_q;           // Last nine bits taken
	logic [9:0]  frame_nxt;         // {stop, parity, data} on the last edge
	logic        fall;
	ps2_byte_t   frame_byte;

	// Device edges only count while the line is ours to watch
	assign fall = clk_prev & ~clk_sync[1] & ~rx.valid & (hold_q == 3'b000);

	assign frame_nxt    = {dat_sync[1], frame_q};        // Shift in from the top
	assign frame_byte   = frame_nxt[7:0];
	assign ps2_clk_oe_o = rx.valid;                      // Back-pressure

	// ----------------------------------------
	// Synchronizers and edge detect
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			clk_sync <= 2'b11;                // Idle lines are high
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
			hold_q   <= 3'b000;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk_i};
			dat_sync <= {dat_sync[0], ps2_dat_i};
			clk_prev <= clk_sync[1];
			hold_q   <= {hold_q[1:0], rx.valid}; // Covers the sync delay after release
		end
	end

	// Frame counter and valid flag
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			bit_cnt_q <= 4'd0;
			rx.valid  <= 1'b0;
		end else begin
			if (rx.ack)
				rx.valid <= 1'b0;               // Arbiter took it
			if (fall) begin
				if (bit_cnt_q == 4'd0 && dat_sync[1])
					bit_cnt_q <= 4'd0;          // No start bit, stay idle
				else if (bit_cnt_q == 4'd10) begin
					bit_cnt_q <= 4'd0;
					rx.valid  <= frame_nxt[9];  // Bad stop bit drops the frame
				end else
					bit_cnt_q <= bit_cnt_q + 4'd1;
			end
		end
	end

	// Shift register and delivered byte
	always_ff @(posedge wb_clk_i) begin
		if (fall)
			frame_q <= frame_nxt[9:1];
		if (fall && bit_cnt_q == 4'd10) begin
			rx.data <= frame_byte;
			rx.perr <= ~^frame_nxt[8:0];        // Data plus parity must be odd
		end
	end

endmodule

//--- source/ps2_rx_if.sv
// ----------------------------------------
// Received-byte handshake, port to arbiter
// ----------------------------------------
`timescale 1ns/10ps

interface ps2_rx_if;

	logic [7:0] data;   // Received byte
	logic       perr;   // Odd parity check failed
	logic       valid;  // Held until ack
	logic       ack;    // One-cycle pulse from the arbiter

	// Receiver side
	modport source (output data, output perr, output valid, input ack);

	// Arbiter side
	modport sink (input data, input perr, input valid, output ack);

endinterface

//--- source/ps2_tx.sv
// ----------------------------------------
// PS/2 host-to-device transmitter
// Inhibit, start, 8 data, parity, stop, ack
// Gives up when the device stops clocking
// ----------------------------------------
`timescale 1ns/10ps

module ps2_tx import ps2_pkg::*; #(
	parameter int TX_INHIBIT_CYCLES = 16,
	parameter int TX_TIMEOUT_CYCLES = 2000
) (
	input  logic      wb_clk_i,
	input  logic      wb_rst_i,
	input  logic      ps2_clk_i,
	input  logic      ps2_dat_i,
	output logic      ps2_clk_oe_o,
	output logic      ps2_dat_oe_o,
	input  logic      start_i,       // Load tx_byte_i and go
	input  ps2_byte_t tx_byte_i,
	output logic      busy_o,
	output logic      timeout_o      // Pulse, no edge in time or no ack
);

	localparam int CNT_W = $clog2(TX_TIMEOUT_CYCLES + TX_INHIBIT_CYCLES + 1);

	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_INHIBIT = 3'd1;  // Clock held low
	localparam logic [2:0] S_START   = 3'd2;  // Data low too, then release clock
	localparam logic [2:0] S_BITS    = 3'd3;  // Data, parity, stop
	localparam logic [2:0] S_ACK     = 3'd4;  // Device acknowledge

	logic [2:0]       state_q;
	logic [CNT_W-1:0] cnt_q;        // Inhibit length, then edge timeout
	logic [3:0]       bit_cnt_q;
	logic [9:0]       shift_q;      // {stop, parity, data}
	logic [1:0]       clk_sync;
	logic [1:0]       dat_sync;
	logic             clk_prev;
	logic             fall;
	logic             waiting;      // Device owes us a clock edge

	assign fall         = clk_prev & ~clk_sync[1];
	assign waiting      = (state_q == S_BITS) || (state_q == S_ACK);
	assign busy_o       = (state_q != S_IDLE);
	assign ps2_clk_oe_o = (state_q == S_INHIBIT) || (state_q == S_START);

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk_i};
			dat_sync <= {dat_sync[0], ps2_dat_i};
			clk_prev <= clk_sync[1];
		end
	end

	// ----------------------------------------
	// Frame FSM
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_q      <= S_IDLE;
			cnt_q        <= '0;
			bit_cnt_q    <= 4'd0;
			ps2_dat_oe_o <= 1'b0;
			timeout_o    <= 1'b0;
		end else begin
			timeout_o <= 1'b0;
			cnt_q     <= cnt_q + 1'b1;
			case (state_q)
				S_IDLE: begin
					cnt_q <= '0;
					if (start_i)
						state_q <= S_INHIBIT;
				end
				S_INHIBIT:
					if (cnt_q == CNT_W'(TX_INHIBIT_CYCLES - 1)) begin
						state_q      <= S_START;
						ps2_dat_oe_o <= 1'b1;       // Start bit
					end
				S_START: begin
					state_q   <= S_BITS;          // Clock goes back to the device
					cnt_q     <= '0;
					bit_cnt_q <= 4'd0;
				end
				S_BITS:
					if (fall) begin
						cnt_q        <= '0;
						ps2_dat_oe_o <= ~shift_q[0];
						bit_cnt_q    <= bit_cnt_q + 4'd1;
						if (bit_cnt_q == 4'd9)
							state_q <= S_ACK;       // Stop bit is out
					end
				S_ACK:
					if (fall) begin
						state_q   <= S_IDLE;
						timeout_o <= dat_sync[1];   // Device left data high
					end
				default: state_q <= S_IDLE;
			endcase
			if (waiting && !fall && cnt_q == CNT_W'(TX_TIMEOUT_CYCLES - 1)) begin
				state_q      <= S_IDLE;           // Device went quiet
				ps2_dat_oe_o <= 1'b0;
				timeout_o    <= 1'b1;
			end
		end
	end

	// Outgoing bits, LSB first
	always_ff @(posedge wb_clk_i) begin
		if (state_q == S_IDLE && start_i)
			shift_q <= {1'b1, ~^tx_byte_i, tx_byte_i};
		else if (state_q == S_BITS && fall)
			shift_q <= {1'b1, shift_q[9:1]};
	end

endmodule

//--- source/ps2_wb_top.sv
// ----------------------------------------
// Wishbone PS/2 controller, 8042 style
// Keyboard receive, mouse receive and transmit
// ----------------------------------------
`timescale 1ns/10ps

module ps2_wb_top import ps2_pkg::*; #(
	parameter int TX_INHIBIT_CYCLES = 16,
	parameter int TX_TIMEOUT_CYCLES = 2000
) (
	input  logic        wb_clk_i,
	input  logic        wb_rst_i,
	input  logic [15:0] wb_dat_i,
	output logic [15:0] wb_dat_o,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic [2:1]  wb_adr_i,
	input  logic [1:0]  wb_sel_i,
	input  logic        wb_we_i,
	output logic        wb_ack_o,
	output logic        wb_tgk_o,
	output logic        wb_tgm_o,
	input  logic        ps2_kbd_clk_i,     // Pads split into sense and pull-low
	input  logic        ps2_kbd_dat_i,
	output logic        ps2_kbd_clk_oe_o,
	input  logic        ps2_mse_clk_i,
	input  logic        ps2_mse_dat_i,
	output logic        ps2_mse_clk_oe_o,
	output logic        ps2_mse_dat_oe_o
);

	ps2_rx_if  kbd_if ();
	ps2_rx_if  mse_if ();

	logic      mse_rx_clk_oe, mse_tx_clk_oe;
	logic      obf, aux, perr, buf_read, kbd_dis, mse_dis;
	logic      tx_start, tx_busy, tx_timeout;
	ps2_byte_t buf_byte, tx_byte;

	assign ps2_mse_clk_oe_o = mse_rx_clk_oe | mse_tx_clk_oe;   // Either side may hold the clock

	ps2_rx kbd_rx (
		.wb_clk_i, .wb_rst_i,
		.ps2_clk_i(ps2_kbd_clk_i), .ps2_dat_i(ps2_kbd_dat_i),
		.ps2_clk_oe_o(ps2_kbd_clk_oe_o), .rx(kbd_if.source)
	);

	ps2_rx mse_rx (
		.wb_clk_i, .wb_rst_i,
		.ps2_clk_i(ps2_mse_clk_i), .ps2_dat_i(ps2_mse_dat_i),
		.ps2_clk_oe_o(mse_rx_clk_oe), .rx(mse_if.source)
	);

	ps2_tx #(
		.TX_INHIBIT_CYCLES(TX_INHIBIT_CYCLES),
		.TX_TIMEOUT_CYCLES(TX_TIMEOUT_CYCLES)
	) mse_tx (
		.wb_clk_i, .wb_rst_i,
		.ps2_clk_i(ps2_mse_clk_i), .ps2_dat_i(ps2_mse_dat_i),
		.ps2_clk_oe_o(mse_tx_clk_oe), .ps2_dat_oe_o(ps2_mse_dat_oe_o),
		.start_i(tx_start), .tx_byte_i(tx_byte),
		.busy_o(tx_busy), .timeout_o(tx_timeout)
	);

	ps2_buf_arbiter buf_arb (
		.wb_clk_i, .wb_rst_i,
		.kbd(kbd_if.sink), .mse(mse_if.sink),
		.kbd_dis_i(kbd_dis), .mse_dis_i(mse_dis), .buf_read_i(buf_read),
		.obf_o(obf), .aux_o(aux), .perr_o(perr), .buf_byte_o(buf_byte)
	);

	ps2_host_regs host (
		.wb_clk_i, .wb_rst_i, .wb_dat_i, .wb_dat_o, .wb_cyc_i, .wb_stb_i,
		.wb_adr_i, .wb_sel_i, .wb_we_i, .wb_ack_o, .wb_tgk_o, .wb_tgm_o,
		.obf_i(obf), .aux_i(aux), .perr_i(perr), .buf_byte_i(buf_byte),
		.buf_read_o(buf_read), .kbd_dis_o(kbd_dis), .mse_dis_o(mse_dis),
		.tx_start_o(tx_start), .tx_byte_o(tx_byte),
		.tx_busy_i(tx_busy), .tx_timeout_i(tx_timeout)
	);

endmodule

//--- tb.f
source/ps2_pkg.sv
source/ps2_rx_if.sv
source/ps2_rx.sv
source/ps2_tx.sv
source/ps2_buf_arbiter.sv
source/ps2_host_regs.sv
source/ps2_wb_top.sv
verif/tb_ps2.sv

//--- verif/tb_ps2.sv
// ----------------------------------------
// Testbench for the Wishbone PS/2 controller
// PS/2 device model, reference model, random frames
// ----------------------------------------
`timescale 1ns/10ps

module tb_ps2 import ps2_pkg::*; ();

	logic        clk, rst, cyc, stb, we;
	logic [15:0] dat_i;
	logic [15:0] dat_o;
	logic [2:1]  adr;
	logic [1:0]  sel;
	logic        ack, tgk, tgm;
	logic        kbd_clk_drv, kbd_dat_drv, mse_clk_drv, mse_dat_drv;
	logic        kbd_clk_oe, mse_clk_oe, mse_dat_oe;
	wire         kbd_clk = kbd_clk_drv & ~kbd_clk_oe;   // Open-collector lines
	wire         kbd_dat = kbd_dat_drv;
	wire         mse_clk = mse_clk_drv & ~mse_clk_oe;
	wire         mse_dat = mse_dat_drv & ~mse_dat_oe;

	integer    seed;
	int        errors;
	int        timeouts;
	ps2_byte_t exp_ctrl;                                // Reference model state
	ps2_byte_t b, rd, st;
	logic      exp_aux;
	logic [9:0] got;

	ps2_wb_top dut0 (
		.wb_clk_i(clk), .wb_rst_i(rst), .wb_dat_i(dat_i), .wb_dat_o(dat_o),
		.wb_cyc_i(cyc), .wb_stb_i(stb), .wb_adr_i(adr), .wb_sel_i(sel), .wb_we_i(we),
		.wb_ack_o(ack), .wb_tgk_o(tgk), .wb_tgm_o(tgm),
		.ps2_kbd_clk_i(kbd_clk), .ps2_kbd_dat_i(kbd_dat), .ps2_kbd_clk_oe_o(kbd_clk_oe),
		.ps2_mse_clk_i(mse_clk), .ps2_mse_dat_i(mse_dat), .ps2_mse_clk_oe_o(mse_clk_oe),
		.ps2_mse_dat_oe_o(mse_dat_oe)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;                         // 40 ns period
	end

	task automatic cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// ----------------------------------------
	// Single-cycle bus access, lane picked by sel[0]
	task automatic bus_access(input logic is_cmd, input logic hi, input logic write,
	                          input ps2_byte_t wbyte, output ps2_byte_t rbyte);
		@(posedge clk);
		#1;
		adr   = is_cmd ? 2'b10 : 2'b00;
		sel   = hi ? 2'b00 : 2'b01;
		we    = write;
		dat_i = hi ? {wbyte, 8'h00} : {8'h00, wbyte};
		cyc   = 1'b1;
		stb   = 1'b1;
		@(negedge clk);
		rbyte = hi ? dat_o[15:8] : dat_o[7:0];          // Stable mid cycle
		if (!ack) begin
			$display("FAILED %0t: no ack on bus access", $time);
			errors++;
		end
		if ((hi ? dat_o[7:0] : dat_o[15:8]) !== 8'h00) begin
			$display("FAILED %0t: unused lane not zero, bus %h", $time, dat_o);
			errors++;
		end
		@(posedge clk);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic bus_write(input logic is_cmd, input logic hi, input ps2_byte_t v);
		ps2_byte_t dummy;
		bus_access(is_cmd, hi, 1'b1, v, dummy);
	endtask

	task automatic bus_read(input logic is_cmd, input logic hi, output ps2_byte_t v);
		bus_access(is_cmd, hi, 1'b0, 8'h00, v);
	endtask

	// Poll status until OBF, bounded
	task automatic wait_obf(output ps2_byte_t s);
		int n;
		n = 0;
		s = 8'h00;
		while (!s[ST_OBF] && n < 1000) begin
			bus_read(1'b1, 1'b0, s);
			n++;
		end
		if (!s[ST_OBF]) begin
			$display("Timeout: output buffer never filled");
			timeouts++;
		end
	endtask

	task automatic wait_not_busy();
		int n;
		ps2_byte_t s;
		n = 0;
		s = 8'h02;
		while (s[ST_BUSY] && n < 2000) begin
			bus_read(1'b1, 1'b0, s);
			n++;
		end
		if (s[ST_BUSY]) begin
			$display("Timeout: transmitter stayed busy");
			timeouts++;
		end
	endtask

	// ----------------------------------------
	// Device model, 10 bus cycles per half clock
	task automatic send_frame(input logic is_mse, input ps2_byte_t v, input logic bad_par);
		logic [10:0] bits;
		int n;
		bits = {1'b1, ~^v ^ bad_par, v, 1'b0};
		n = 0;
		while (!(is_mse ? mse_clk : kbd_clk) && n < 20000) begin
			@(posedge clk);                              // Host inhibit
			n++;
		end
		if (n >= 20000) begin
			$display("Timeout: host held the clock low");
			timeouts++;
		end
		for (int i = 0; i < 11; i++) begin
			if (is_mse) mse_dat_drv = bits[i];
			else kbd_dat_drv = bits[i];
			cycles(5);
			if (is_mse) mse_clk_drv = 1'b0;
			else kbd_clk_drv = 1'b0;
			cycles(10);
			if (is_mse) mse_clk_drv = 1'b1;
			else kbd_clk_drv = 1'b1;
			cycles(5);
		end
		mse_dat_drv = 1'b1;
		kbd_dat_drv = 1'b1;
	endtask

	// Clock in a host-to-device frame and acknowledge
	task automatic recv_frame(output logic [9:0] bits);
		int n;
		n = 0;
		while (!(mse_dat_oe && !mse_clk_oe) && n < 500) begin
			@(posedge clk);                              // Start bit with clock released
			n++;
		end
		if (n >= 500) begin
			$display("Timeout: no request to send from host");
			timeouts++;
		end
		for (int i = 0; i < 10; i++) begin
			cycles(5);
			mse_clk_drv = 1'b0;
			cycles(10);
			mse_clk_drv = 1'b1;
			cycles(3);
			bits[i] = mse_dat;                           // Host changed data on the fall
			cycles(2);
		end
		mse_dat_drv = 1'b0;                              // Acknowledge
		cycles(5);
		mse_clk_drv = 1'b0;
		cycles(10);
		mse_clk_drv = 1'b1;
		cycles(5);
		mse_dat_drv = 1'b1;
	endtask

	// Receive one frame on a port and check it through the registers
	task automatic check_rx(input logic is_mse, input logic hi, input logic bad_par,
	                        input logic irq_on);
		ps2_byte_t v, s, r;
		v = 8'($random(seed));
		send_frame(is_mse, v, bad_par);
		wait_obf(s);
		exp_aux = is_mse;
		if (s[ST_AUX] !== exp_aux || s[ST_PERR] !== bad_par) begin
			$display("FAILED %0t: status %h, aux %b perr %b expected", $time, s, exp_aux, bad_par);
			errors++;
		end
		if ((is_mse ? tgm : tgk) !== irq_on || (is_mse ? tgk : tgm) !== 1'b0) begin
			$display("FAILED %0t: interrupts tgk %b tgm %b", $time, tgk, tgm);
			errors++;
		end
		bus_read(1'b0, hi, r);
		if (r !== v) begin
			$display("FAILED %0t: data read %h, expected %h", $time, r, v);
			errors++;
		end
		@(negedge clk);
		if (tgk !== 1'b0 || tgm !== 1'b0) begin
			$display("FAILED %0t: interrupt still high after read", $time);
			errors++;
		end
	endtask

	task automatic write_ctrl(input ps2_byte_t v);
		bus_write(1'b1, 1'b0, CMD_WR_CTRL);
		bus_write(1'b0, 1'b0, v);
		exp_ctrl = v;
	endtask

	// Command with a one-byte reply
	task automatic check_reply(input ps2_byte_t cmd, input ps2_byte_t exp, input logic hi);
		ps2_byte_t r;
		bus_write(1'b1, hi, cmd);
		bus_read(1'b0, hi, r);
		if (r !== exp) begin
			$display("FAILED %0t: command %h reply %h, expected %h", $time, cmd, r, exp);
			errors++;
		end
	endtask

	// ----------------------------------------
	initial begin
		seed = 32'h6866;
		errors = 0;
		timeouts = 0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		adr = 2'b00;
		sel = 2'b01;
		dat_i = 16'h0000;
		kbd_clk_drv = 1'b1;
		kbd_dat_drv = 1'b1;
		mse_clk_drv = 1'b1;
		mse_dat_drv = 1'b1;
		exp_ctrl = CTRL_DEFAULT;
		cycles(3);
		#1 rst = 1'b0;

		// Reset state
		bus_read(1'b1, 1'b0, st);
		if (st !== 8'h14 || tgk || tgm || kbd_clk_oe || mse_clk_oe || mse_dat_oe) begin
			$display("FAILED %0t: reset state, status %h", $time, st);
			errors++;
		end
		check_reply(CMD_RD_CTRL, exp_ctrl, 1'b0);

		// Random frames, both lanes
		for (int i = 0; i < 6; i++)
			check_rx(1'b0, i[0], 1'b0, 1'b1);
		for (int i = 0; i < 4; i++)
			check_rx(1'b1, i[0], 1'b0, 1'b1);
		check_rx(1'b1, 1'b0, 1'b1, 1'b1);                 // Bad parity

		// Control byte read-back
		for (int i = 0; i < 4; i++) begin
			write_ctrl(8'($random(seed)));
			check_reply(CMD_RD_CTRL, exp_ctrl, i[0]);
		end
		write_ctrl(8'h44);                               // Interrupts off
		check_rx(1'b0, 1'b0, 1'b0, 1'b0);
		check_rx(1'b1, 1'b1, 1'b0, 1'b0);

		// Keyboard disabled, byte waits with the clock held
		write_ctrl(8'h47 | (8'h01 << CT_KDIS));
		b = 8'($random(seed));
		send_frame(1'b0, b, 1'b0);
		cycles(50);
		bus_read(1'b1, 1'b0, st);
		if (st[ST_OBF] || !kbd_clk_oe) begin
			$display("FAILED %0t: disabled keyboard, status %h clk_oe %b", $time, st, kbd_clk_oe);
			errors++;
		end
		write_ctrl(CTRL_DEFAULT);
		wait_obf(st);
		bus_read(1'b0, 1'b0, rd);
		if (rd !== b) begin
			$display("FAILED %0t: held keyboard byte %h, expected %h", $time, rd, b);
			errors++;
		end

		// Replies and A2
		check_reply(CMD_SELF_TEST, SELF_TEST_OK, 1'b0);
		check_reply(CMD_MSE_TEST, MSE_TEST_OK, 1'b1);
		bus_write(1'b1, 1'b0, CMD_SELF_TEST);
		bus_read(1'b1, 1'b0, st);
		if (!st[ST_A2]) begin
			$display("FAILED %0t: A2 clear after command write", $time);
			errors++;
		end
		bus_read(1'b0, 1'b0, rd);
		bus_write(1'b0, 1'b0, 8'h00);
		bus_read(1'b1, 1'b0, st);
		if (st[ST_A2]) begin
			$display("FAILED %0t: A2 set after data write", $time);
			errors++;
		end

		// Mouse transmit, random bytes
		for (int i = 0; i < 3; i++) begin
			b = 8'($random(seed));
			bus_write(1'b1, 1'b0, CMD_MSE_WRITE);
			bus_write(1'b0, 1'b0, b);
			bus_read(1'b1, 1'b0, st);
			if (!st[ST_BUSY]) begin
				$display("FAILED %0t: busy not set after mouse write", $time);
				errors++;
			end
			recv_frame(got);
			if (got[7:0] !== b || got[8] !== ~^b || got[9] !== 1'b1) begin
				$display("FAILED %0t: mouse got %b, sent %h", $time, got, b);
				errors++;
			end
			wait_not_busy();
			bus_read(1'b1, 1'b0, st);
			if (st[ST_TO]) begin
				$display("FAILED %0t: timeout set after good frame", $time);
				errors++;
			end
		end

		// No device clocks, transmit times out
		bus_write(1'b1, 1'b0, CMD_MSE_WRITE);
		bus_write(1'b0, 1'b0, 8'h5A);
		wait_not_busy();
		bus_read(1'b1, 1'b0, st);
		if (!st[ST_TO] || st[ST_BUSY]) begin
			$display("FAILED %0t: no timeout, status %h", $time, st);
			errors++;
		end

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
